/* include/rp_defines.svh */
////////////////////////////////////////
// fixed board widths and register map
// offsets are byte addresses on an 8-bit bus
////////////////////////////////////////

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// sample streams
`define RP_SAMPLE_W       14  // ADC and DAC word width
`define RP_ADC_FILL_BITS  2   // low ADC bits overwritten with bit 2

// wishbone
`define RP_ADR_W          8   // byte address
`define RP_DAT_W          32  // data bus

// register map
`define RP_OFS_ID         8'h00  // identification, read only
`define RP_OFS_CFG        8'h04  // bit 0 digital loopback
`define RP_OFS_LED        8'h08  // led byte

// identification word, "RP" plus a revision
`define RP_ID_VALUE       32'h5250_0001

`endif

/* rtl/rp_bus_pkg.sv */
////////////////////////////////////////
// wishbone classic request/response types
// single master, no bursts, no tags
////////////////////////////////////////

`include "rp_defines.svh"

package rp_bus_pkg;

  ////////////////////////////////////////
  // bus payloads

  // driven by the master
  typedef struct packed {
    logic                 cyc;  // cycle in progress
    logic                 stb;  // strobe
    logic                 we;   // 1 write, 0 read
    logic [`RP_ADR_W-1:0] adr;  // byte address
    logic [`RP_DAT_W-1:0] dat;  // write data
  } wb_req_t;

  // driven by the slave
  typedef struct packed {
    logic                 ack;  // access done
    logic                 err;  // unmapped offset
    logic [`RP_DAT_W-1:0] dat;  // read data, valid with ack
  } wb_rsp_t;

  ////////////////////////////////////////
  // decode and control

  // register offsets
  typedef enum logic [`RP_ADR_W-1:0] {
    REG_ID  = `RP_OFS_ID,
    REG_CFG = `RP_OFS_CFG,
    REG_LED = `RP_OFS_LED
  } reg_ofs_e;

  // slave phases
  typedef enum logic {
    BUS_IDLE,  // waiting for cyc & stb
    BUS_ACK    // answering, one clock
  } bus_state_e;

endpackage

/* rtl/rp_data_pkg.sv */
////////////////////////////////////////
// sample stream types, two channels fixed
////////////////////////////////////////

`include "rp_defines.svh"

package rp_data_pkg;

  // two's complement sample
  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;

  // one sample per channel per adc_clk
  typedef struct packed {
    sample_t ch_a;  // channel A / out 1
    sample_t ch_b;  // channel B / out 2
  } sample_pair_t;

  // sum of two samples, one guard bit
  typedef logic signed [`RP_SAMPLE_W:0] sum_t;

endpackage

/* rtl/rp_regs.sv */
////////////////////////////////////////
// wishbone classic slave, answers one clock after the request
// master must drop stb for a clock after ack or err
////////////////////////////////////////

`include "rp_defines.svh"

module rp_regs (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  rp_bus_pkg::wb_req_t wb_req_i,
  output rp_bus_pkg::wb_rsp_t wb_rsp_o,
  output logic                digital_loop_o,
  output logic [8-1:0]        led_o
);

////////////////////////////////////////
// local signals

rp_bus_pkg::bus_state_e state_q;  // idle or ack phase
logic                   req;      // new access this clock
logic                   hit;      // mapped offset
logic                   sel_cfg;  // config register addressed
logic                   sel_led;  // led register addressed
logic [`RP_DAT_W-1:0]   rdat;     // read mux
logic [`RP_DAT_W-1:0]   rdat_q;   // read data held for the ack cycle
logic                   err_q;    // answer with err instead of ack
logic                   loop_q;   // digital loopback enable
logic [8-1:0]           led_q;    // led byte as written

// only start while idle, held request during ack is the same access
assign req = wb_req_i.cyc & wb_req_i.stb & (state_q == rp_bus_pkg::BUS_IDLE);

////////////////////////////////////////
// offset decode and read mux

always_comb
begin
  hit     = 1'b1;
  sel_cfg = 1'b0;
  sel_led = 1'b0;
  rdat    = '0;  // unused bits read zero
  case (rp_bus_pkg::reg_ofs_e'(wb_req_i.adr))
    rp_bus_pkg::REG_ID:
    begin
      rdat = `RP_ID_VALUE;  // writes ignored
    end
    rp_bus_pkg::REG_CFG:
    begin
      sel_cfg = 1'b1;
      rdat[0] = loop_q;
    end
    rp_bus_pkg::REG_LED:
    begin
      sel_led   = 1'b1;
      rdat[7:0] = led_q;  // unswapped on read
    end
    default:
    begin
      hit = 1'b0;  // err
    end
  endcase
end

////////////////////////////////////////
// bus FSM

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    state_q <= rp_bus_pkg::BUS_IDLE;
    err_q   <= 1'b0;
  end
  else
  begin
    case (state_q)
      rp_bus_pkg::BUS_IDLE:
      begin
        if (req)
        begin
          state_q <= rp_bus_pkg::BUS_ACK;
          err_q   <= ~hit;
        end
      end
      default:
      begin
        state_q <= rp_bus_pkg::BUS_IDLE;  // single clock answer
      end
    endcase
  end
end

// capture read data with the request
always_ff @(posedge adc_clk)
begin
  if (req)
    rdat_q <= rdat;
end

////////////////////////////////////////
// registers, written on the edge that raises ack

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    loop_q <= 1'b0;
    led_q  <= '0;
  end
  else if (req & wb_req_i.we)
  begin
    if (sel_cfg)
      loop_q <= wb_req_i.dat[0];
    if (sel_led)
      led_q <= wb_req_i.dat[7:0];
  end
end

assign wb_rsp_o = '{ack: (state_q == rp_bus_pkg::BUS_ACK) & ~err_q,
                    err: (state_q == rp_bus_pkg::BUS_ACK) &  err_q,
                    dat: rdat_q};

assign digital_loop_o = loop_q;
assign led_o          = {led_q[3:0], led_q[7:4]};  // nibbles swapped on the board

endmodule

/* rtl/rp_adc_path.sv */
////////////////////////////////////////
// ADC words arrive deserialized and aligned to adc_clk
// one register from input to adc_dat_o
////////////////////////////////////////

`include "rp_defines.svh"

module rp_adc_path (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  rp_data_pkg::sample_pair_t adc_dat_i,       // raw ADC A / ADC B
  input  rp_data_pkg::sample_pair_t dac_word_i,      // DAC word before its registers
  input  logic                     digital_loop_i,
  output rp_data_pkg::sample_pair_t adc_dat_o
);

////////////////////////////////////////
// formatting

// low bits are noisy on this converter, replicate bit 2 into them
function automatic rp_data_pkg::sample_t fmt_adc(input rp_data_pkg::sample_t raw);
  return {raw[`RP_SAMPLE_W-1:`RP_ADC_FILL_BITS],
          {`RP_ADC_FILL_BITS{raw[`RP_ADC_FILL_BITS]}}};
endfunction

rp_data_pkg::sample_pair_t adc_sw;  // formatted and crossed

// board routes ADC B to channel A and ADC A to channel B
always_comb
begin
  adc_sw.ch_a = fmt_adc(adc_dat_i.ch_b);  // adc_b -> ch_a
  adc_sw.ch_b = fmt_adc(adc_dat_i.ch_a);  // adc_a -> ch_b
end

////////////////////////////////////////
// loopback select and output register

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    adc_dat_o <= '0;
  end
  else
  begin
    // loopback keeps channel order, DAC side already crosses at its pins
    adc_dat_o <= digital_loop_i ? dac_word_i : adc_sw;
  end
end

endmodule

/* rtl/rp_dac_path.sv */
////////////////////////////////////////
// generator plus feedback per channel, saturated then inverted
// DAC has negative slope, two registers to the pins
////////////////////////////////////////

`include "rp_defines.svh"

module rp_dac_path (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  rp_data_pkg::sample_pair_t asg_dat_i,    // generator samples
  input  rp_data_pkg::sample_pair_t pid_dat_i,    // feedback controller samples
  output rp_data_pkg::sample_pair_t dac_word_o,   // combinational, to loopback
  output rp_data_pkg::sample_pair_t dac_dat_o,    // to DAC pins, crossed
  output logic                     dac_reset_o
);

////////////////////////////////////////
// sum, clamp, invert

// top two bits differ only when the sum left the 14-bit range
function automatic rp_data_pkg::sample_t sat_inv(input rp_data_pkg::sum_t sum);
  rp_data_pkg::sample_t sat;
  if (sum[`RP_SAMPLE_W] != sum[`RP_SAMPLE_W-1])
    sat = {sum[`RP_SAMPLE_W], {(`RP_SAMPLE_W-1){~sum[`RP_SAMPLE_W]}}};  // clamp to sign
  else
    sat = sum[`RP_SAMPLE_W-1:0];
  return ~sat;  // neg-slope code
endfunction

rp_data_pkg::sum_t         sum_a;  // ch A, one guard bit
rp_data_pkg::sum_t         sum_b;  // ch B
rp_data_pkg::sample_pair_t dac_q;  // first stage

assign sum_a = $signed(asg_dat_i.ch_a) + $signed(pid_dat_i.ch_a);  // sign extended
assign sum_b = $signed(asg_dat_i.ch_b) + $signed(pid_dat_i.ch_b);

assign dac_word_o = '{ch_a: sat_inv(sum_a), ch_b: sat_inv(sum_b)};

////////////////////////////////////////
// output registers

always_ff @(posedge adc_clk)
begin
  if (reset_i)
  begin
    dac_q     <= '0;
    dac_dat_o <= '0;
  end
  else
  begin
    dac_q          <= dac_word_o;
    dac_dat_o.ch_a <= dac_q.ch_b;  // ch_b -> dac_a
    dac_dat_o.ch_b <= dac_q.ch_a;  // ch_a -> dac_b
  end
end

// DAC reset trails system reset by one clock
always_ff @(posedge adc_clk)
begin
  dac_reset_o <= reset_i;
end

endmodule

/* rtl/rp_top.sv */
////////////////////////////////////////
// single clock domain, everything on adc_clk
// generator and feedback streams come in as ports
////////////////////////////////////////

module rp_top (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  // register bus
  input  rp_bus_pkg::wb_req_t       wb_req_i,
  output rp_bus_pkg::wb_rsp_t       wb_rsp_o,
  // sample streams
  input  rp_data_pkg::sample_pair_t adc_dat_i,   // raw ADC A / ADC B
  input  rp_data_pkg::sample_pair_t asg_dat_i,   // generator
  input  rp_data_pkg::sample_pair_t pid_dat_i,   // feedback controller
  output rp_data_pkg::sample_pair_t adc_dat_o,   // acquired ch A / ch B
  output rp_data_pkg::sample_pair_t dac_dat_o,   // DAC pins
  output logic                      dac_reset_o,
  // board
  output logic [8-1:0]              led_o
);

////////////////////////////////////////
// local signals

logic                      digital_loop;  // from config register
rp_data_pkg::sample_pair_t dac_word;      // DAC code before pipeline

////////////////////////////////////////
// register block

rp_regs i_regs (
  .adc_clk        (adc_clk     ),
  .reset_i        (reset_i     ),
  .wb_req_i       (wb_req_i    ),
  .wb_rsp_o       (wb_rsp_o    ),
  .digital_loop_o (digital_loop),
  .led_o          (led_o       )  // already nibble swapped
);

////////////////////////////////////////
// acquisition

rp_adc_path i_adc (
  .adc_clk        (adc_clk     ),
  .reset_i        (reset_i     ),
  .adc_dat_i      (adc_dat_i   ),
  .dac_word_i     (dac_word    ),  // loopback source
  .digital_loop_i (digital_loop),
  .adc_dat_o      (adc_dat_o   )
);

////////////////////////////////////////
// generation

rp_dac_path i_dac (
  .adc_clk        (adc_clk     ),
  .reset_i        (reset_i     ),
  .asg_dat_i      (asg_dat_i   ),
  .pid_dat_i      (pid_dat_i   ),
  .dac_word_o     (dac_word    ),
  .dac_dat_o      (dac_dat_o   ),
  .dac_reset_o    (dac_reset_o )
);

endmodule

/* dv/tb_rp_top.sv */
////////////////////////////////////////
// inputs driven on the falling edge, checks sampled on the rising edge
// reference model tracks the register map from the bus traffic it drives
////////////////////////////////////////

`include "rp_defines.svh"

module tb_rp_top;

localparam int TIMEOUT_CYCLES = 2000;  // tests need about 1200
localparam rp_data_pkg::sample_t S_MAX = 14'sh1fff;  // most positive sample
localparam rp_data_pkg::sample_t S_MIN = 14'sh2000;  // most negative sample

logic                      adc_clk = 1'b0;
logic                      reset_i;
rp_bus_pkg::wb_req_t       wb_req_i;
rp_bus_pkg::wb_rsp_t       wb_rsp_o;
rp_data_pkg::sample_pair_t adc_dat_i, asg_dat_i, pid_dat_i;
rp_data_pkg::sample_pair_t adc_dat_o, dac_dat_o;
logic                      dac_reset_o;
logic [8-1:0]              led_o;

integer seed = 23830;
int     cycle_cnt = 0;

// reference model state
logic                      chk_en = 1'b0;  // skip the very first edge
logic                      model_busy, model_loop, exp_ack, exp_err, exp_dac_rst;
logic [8-1:0]              model_led;
logic [`RP_DAT_W-1:0]      exp_rdat;
rp_data_pkg::sample_pair_t exp_adc, exp_stage, exp_dac;

rp_top i_dut (
  .adc_clk     (adc_clk    ),
  .reset_i     (reset_i    ),
  .wb_req_i    (wb_req_i   ),
  .wb_rsp_o    (wb_rsp_o   ),
  .adc_dat_i   (adc_dat_i  ),
  .asg_dat_i   (asg_dat_i  ),
  .pid_dat_i   (pid_dat_i  ),
  .adc_dat_o   (adc_dat_o  ),
  .dac_dat_o   (dac_dat_o  ),
  .dac_reset_o (dac_reset_o),
  .led_o       (led_o      )
);

always #10 adc_clk = ~adc_clk;  // period 20

////////////////////////////////////////
// reference functions

// low bits take the value of bit 2
function automatic rp_data_pkg::sample_t fmt_model(input rp_data_pkg::sample_t raw);
  rp_data_pkg::sample_t r;
  r = raw;
  for (int i = 0; i < `RP_ADC_FILL_BITS; i++)
    r[i] = raw[`RP_ADC_FILL_BITS];
  return r;
endfunction

// clamp the true sum, then invert for the DAC
function automatic rp_data_pkg::sample_t dac_code(input rp_data_pkg::sample_t g,
                                                  input rp_data_pkg::sample_t p);
  int s;
  rp_data_pkg::sample_t c;
  s = int'(g) + int'(p);
  if (s > int'(S_MAX))
    s = int'(S_MAX);
  else if (s < int'(S_MIN))
    s = int'(S_MIN);
  c = rp_data_pkg::sample_t'(s);
  return ~c;
endfunction

function automatic logic offset_mapped(input logic [`RP_ADR_W-1:0] adr);
  return (adr == `RP_OFS_ID) || (adr == `RP_OFS_CFG) || (adr == `RP_OFS_LED);
endfunction

function automatic logic [`RP_DAT_W-1:0] read_value(input logic [`RP_ADR_W-1:0] adr);
  case (adr)
    `RP_OFS_ID:  return `RP_ID_VALUE;
    `RP_OFS_CFG: return {31'b0, model_loop};  // unused bits zero
    `RP_OFS_LED: return {24'b0, model_led};
    default:     return '0;
  endcase
endfunction

////////////////////////////////////////
// reference model updated once per rising edge

always @(posedge adc_clk)
begin
  logic new_req;
  rp_data_pkg::sample_pair_t word;
  chk_en      <= 1'b1;
  exp_dac_rst <= reset_i;  // DAC reset one clock behind
  new_req  = wb_req_i.cyc & wb_req_i.stb & ~model_busy;
  word.ch_a = dac_code(asg_dat_i.ch_a, pid_dat_i.ch_a);
  word.ch_b = dac_code(asg_dat_i.ch_b, pid_dat_i.ch_b);
  if (reset_i)
  begin
    model_busy <= 1'b0;
    model_loop <= 1'b0;
    model_led  <= '0;
    exp_ack    <= 1'b0;
    exp_err    <= 1'b0;
    exp_adc    <= '0;
    exp_stage  <= '0;
    exp_dac    <= '0;
  end
  else
  begin
    // loopback keeps order while ADC inputs cross
    exp_adc <= model_loop ? word
                          : rp_data_pkg::sample_pair_t'{ch_a: fmt_model(adc_dat_i.ch_b),
                                                        ch_b: fmt_model(adc_dat_i.ch_a)};
    exp_stage <= word;
    exp_dac   <= '{ch_a: exp_stage.ch_b, ch_b: exp_stage.ch_a};  // crossed at pins
    model_busy <= new_req;
    exp_ack    <= new_req & offset_mapped(wb_req_i.adr);
    exp_err    <= new_req & ~offset_mapped(wb_req_i.adr);
    if (new_req)
    begin
      exp_rdat <= read_value(wb_req_i.adr);  // old contents on a write
      if (wb_req_i.we && wb_req_i.adr == `RP_OFS_CFG)
        model_loop <= wb_req_i.dat[0];
      if (wb_req_i.we && wb_req_i.adr == `RP_OFS_LED)
        model_led <= wb_req_i.dat[7:0];
    end
  end
end

////////////////////////////////////////
// checks

task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
  $display("FAILED time %0t %s expected %h actual %h", $time, name, exp_val, act_val);
  $display("Testbench failed");
  $fatal(1, "value mismatch on %s", name);
endtask

assert property (@(posedge adc_clk) chk_en |-> dac_reset_o == exp_dac_rst)
  else report_mismatch("dac_reset_o", exp_dac_rst, $sampled(dac_reset_o));
assert property (@(posedge adc_clk) chk_en |-> wb_rsp_o.ack == exp_ack)
  else report_mismatch("wb_rsp_o.ack", exp_ack, $sampled(wb_rsp_o.ack));
assert property (@(posedge adc_clk) chk_en |-> wb_rsp_o.err == exp_err)
  else report_mismatch("wb_rsp_o.err", exp_err, $sampled(wb_rsp_o.err));
assert property (@(posedge adc_clk) chk_en && exp_ack |-> wb_rsp_o.dat == exp_rdat)
  else report_mismatch("wb_rsp_o.dat", exp_rdat, $sampled(wb_rsp_o.dat));
assert property (@(posedge adc_clk) chk_en |-> led_o == {model_led[3:0], model_led[7:4]})
  else report_mismatch("led_o", {model_led[3:0], model_led[7:4]}, $sampled(led_o));
assert property (@(posedge adc_clk) chk_en |-> adc_dat_o == exp_adc)
  else report_mismatch("adc_dat_o", exp_adc, $sampled(adc_dat_o));
assert property (@(posedge adc_clk) chk_en |-> dac_dat_o == exp_dac)
  else report_mismatch("dac_dat_o", exp_dac, $sampled(dac_dat_o));

////////////////////////////////////////
// stimulus

// random streams with overflow and ADC corners mixed in
task automatic drive_samples();
  logic [31:0] r;
  r = $random(seed);
  adc_dat_i = r[27:0];
  r = $random(seed);
  asg_dat_i = r[27:0];
  r = $random(seed);
  pid_dat_i = r[27:0];
  r = $random(seed);
  case (r[2:0])
    3'd0:
    begin
      asg_dat_i = '{ch_a: S_MAX, ch_b: S_MIN};  // A up, B down
      pid_dat_i = '{ch_a: S_MAX, ch_b: S_MIN};
    end
    3'd1:
    begin
      asg_dat_i = '{ch_a: S_MIN, ch_b: S_MAX};  // A down, B up
      pid_dat_i = '{ch_a: S_MIN, ch_b: S_MAX};
    end
    3'd2:    adc_dat_i = '{ch_a: S_MAX, ch_b: S_MIN};
    3'd3:    adc_dat_i = '{ch_a: S_MIN, ch_b: S_MAX};
    default: ;  // plain random
  endcase
endtask

always @(negedge adc_clk)
  drive_samples();

// one classic access held until ack or err with stb low for a clock after
task automatic bus_access(input logic we, input logic [`RP_ADR_W-1:0] adr,
                          input logic [`RP_DAT_W-1:0] dat);
  @(negedge adc_clk);
  wb_req_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
  do
    @(negedge adc_clk);
  while (!(wb_rsp_o.ack || wb_rsp_o.err));
  wb_req_i = '0;
endtask

task automatic bus_write(input logic [`RP_ADR_W-1:0] adr, input logic [`RP_DAT_W-1:0] dat);
  bus_access(1'b1, adr, dat);
endtask

task automatic bus_read(input logic [`RP_ADR_W-1:0] adr);
  bus_access(1'b0, adr, '0);
endtask

// run limit
always @(posedge adc_clk)
begin
  cycle_cnt <= cycle_cnt + 1;
  if (cycle_cnt >= TIMEOUT_CYCLES)
  begin
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $fatal(1, "run limit reached");
  end
end

initial
begin
  logic [31:0] r;
  reset_i   = 1'b1;
  wb_req_i  = '0;
  adc_dat_i = '0;
  asg_dat_i = '0;
  pid_dat_i = '0;
  repeat (5) @(negedge adc_clk);
  reset_i = 1'b0;

  repeat (250) @(negedge adc_clk);  // crossed acquisition, generation
  bus_read(`RP_OFS_ID);
  bus_write(`RP_OFS_ID, 32'hdead_beef);  // ignored
  bus_read(`RP_OFS_ID);

  bus_write(`RP_OFS_CFG, 32'hffff_ffff);  // loopback on with upper bits dropped
  bus_read(`RP_OFS_CFG);
  repeat (400) @(negedge adc_clk);

  r = $random(seed);
  bus_write(`RP_OFS_LED, {r[31:8], 8'ha5});
  bus_read(`RP_OFS_LED);
  bus_write(`RP_OFS_LED, r);
  bus_read(`RP_OFS_LED);

  bus_read(8'h0c);  // unmapped
  bus_write(8'h0c, r);

  bus_write(`RP_OFS_CFG, 32'h0);  // back to crossed ADC
  bus_read(`RP_OFS_CFG);
  repeat (400) @(negedge adc_clk);

  $display("Testbench passed");
  $finish;
end

endmodule

/* sim.f */
+incdir+include
rtl/rp_bus_pkg.sv
rtl/rp_data_pkg.sv
rtl/rp_regs.sv
rtl/rp_adc_path.sv
rtl/rp_dac_path.sv
rtl/rp_top.sv
dv/tb_rp_top.sv
